/* all.f */
hdl/dzPkg.sv
hdl/dzCsr.sv
hdl/dzTdr.sv
hdl/dzUartTx.sv
hdl/dzScan.sv
hdl/dzTx.sv
tb/dzTx_properties.sv
tb/dzTxTb.sv

/* hdl/dzCsr.sv */
/*
 * APB register block for the transmit multiplexer.
 * Holds CSR MSE and the TCR line enables with byte-lane writes,
 * muxes read data with TRDY and TLINE live from the scanner, and
 * issues a one-cycle TDR write strobe with the captured byte.
 */

`timescale 1ns/100ps

module dzCsr import dzPkg::*; (
      input  logic       clk,          // Clock
      input  logic       rstN,         // Async reset, active low
      input  logic       psel,         // APB select
      input  logic       penable,      // APB access phase
      input  logic       pwrite,       // APB write
      input  apbAddrT    paddr,        // APB byte address
      input  regDataT    pwdata,       // APB write data
      input  logic [1:0] pstrb,        // APB byte strobes
      input  logic       trdy,         // Scanner found a ready line
      input  lineSelT    tLine,        // Scanner line number
      output regDataT    prdata,       // APB read data
      output logic       tdrWrite,     // TDR low-byte write strobe
      output uartDataT   tdrData,      // TDR byte
      output logic       mse,          // Master scan enable
      output lineMaskT   lineEnable    // TCR line enables
   );

   ////////////////////////////////////////
   // Access decode
   ////////////////////////////////////////

   logic wrAccess;
   logic loLane;
   logic csrWrLo;
   logic tcrWrLo;
   logic tdrWrLo;

   // Writes land on the edge ending the access cycle
   assign wrAccess = psel & penable & pwrite;

   // Only the low lane carries writable bits here
   assign loLane   = pstrb[0];

   assign csrWrLo  = wrAccess & loLane & (paddr == csrAddr);
   assign tcrWrLo  = wrAccess & loLane & (paddr == tcrAddr);
   assign tdrWrLo  = wrAccess & loLane & (paddr == tdrAddr);

   ////////////////////////////////////////
   // Control registers
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         mse        <= 1'b0;
         lineEnable <= '0;
         tdrWrite   <= 1'b0;
      end
      else
      begin
         // CSR MSE sits in the low byte
         if (csrWrLo)
            mse <= pwdata[csrMseBit];
         // TCR enables
         if (tcrWrLo)
            lineEnable <= pwdata[7:0];
         // Strobe valid in the cycle after the access
         tdrWrite <= tdrWrLo;
      end
   end

   // Byte for the transmitters
   always_ff @(posedge clk)
   begin
      if (tdrWrLo)
         tdrData <= pwdata[7:0];
   end

   ////////////////////////////////////////
   // Read mux
   ////////////////////////////////////////

   always_comb
   begin
      prdata = '0;
      if (psel && !pwrite)
      begin
         case (paddr)
            // TRDY, TLINE, MSE; everything else zero
            csrAddr: prdata = {trdy, 4'b0000, tLine, 2'b00, mse, 5'b00000};
            tcrAddr: prdata = {8'h00, lineEnable};
            // TDR is write-only
            default: prdata = '0;
         endcase
      end
   end

endmodule

/* hdl/dzPkg.sv */
/*
 * Shared constants and types for the DZ11-style transmit multiplexer.
 * Holds line count, serial bit timing, APB register offsets, the
 * vector typedefs and the transmitter state enum. Imported by the RTL.
 */

package dzPkg;

   ////////////////////////////////////////
   // Line and bit timing
   ////////////////////////////////////////

   // Serial lines served by the multiplexer
   localparam int numLines   = 8;

   // Clocks per serial bit, fixed baud
   localparam int clksPerBit = 4;

   // Width of the bit-time counter
   localparam int bitCntW    = $clog2(clksPerBit);

   ////////////////////////////////////////
   // Register map
   ////////////////////////////////////////

   // Byte offsets on the APB side
   localparam logic [3:0] csrAddr = 4'd0;
   localparam logic [3:0] tcrAddr = 4'd2;
   localparam logic [3:0] tdrAddr = 4'd6;

   // Master scan enable position in CSR
   localparam int csrMseBit = 5;

   ////////////////////////////////////////
   // Types
   ////////////////////////////////////////

   typedef logic [3:0]  apbAddrT;   // APB byte address
   typedef logic [15:0] regDataT;   // Register and bus data
   typedef logic [7:0]  uartDataT;  // One character
   typedef logic [2:0]  lineSelT;   // Line number
   typedef logic [7:0]  lineMaskT;  // One bit per line

   // Transmitter frame states
   typedef enum logic [1:0] {
      txIdle,
      txStart,
      txData,
      txStop
   } txStateT;

endpackage

/* hdl/dzScan.sv */
/*
 * Round-robin transmit line scanner.
 * With MSE set it steps one line per clock until it finds a line
 * that is enabled and empty, then raises TRDY and holds TLINE until
 * that line goes busy or loses its enable or MSE.
 */

`timescale 1ns/100ps

module dzScan import dzPkg::*; (
      input  logic     clk,          // Clock
      input  logic     rstN,         // Async reset, active low
      input  logic     mse,          // Master scan enable
      input  lineMaskT lineEnable,   // TCR line enables
      input  lineMaskT txEmpty,      // Per-line transmitter empty
      output logic     trdy,         // Line ready for a byte
      output lineSelT  tLine         // Line under the pointer
   );

   ////////////////////////////////////////
   // Line qualify
   ////////////////////////////////////////

   logic lineOk;

   // Current pointer names a usable line
   assign lineOk = mse & lineEnable[tLine] & txEmpty[tLine];

   ////////////////////////////////////////
   // Pointer and TRDY
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         trdy  <= 1'b0;
         tLine <= '0;
      end
      else if (trdy)
      begin
         // Hold until the line is taken or disqualified
         if (!lineOk)
         begin
            trdy  <= 1'b0;
            tLine <= tLine + 1'b1;
         end
      end
      else if (mse)
      begin
         if (lineOk)
            trdy <= 1'b1;
         else
            tLine <= tLine + 1'b1;
      end
   end

   // Scanner idles in place with MSE clear
   // Wraps from line 7 back to line 0 by width

endmodule

/* hdl/dzTdr.sv */
/*
 * Transmit data register decode.
 * Turns a TDR low-byte write strobe into a one-hot load for the
 * line named by TLINE; the byte passes straight to every UART.
 */

`timescale 1ns/100ps

module dzTdr import dzPkg::*; (
      input  logic     tdrWrite,   // TDR low-byte write strobe
      input  lineSelT  tLine,      // Line selected by the scanner
      input  uartDataT tdrData,    // Byte written to TDR
      output lineMaskT txLoad,     // One-hot UART load
      output uartDataT txData      // Byte to the UARTs
   );

   ////////////////////////////////////////
   // Load decode
   ////////////////////////////////////////

   // Zero unless a write is in progress
   always_comb
   begin
      txLoad = '0;
      if (tdrWrite)
      begin
         case (tLine)
            3'd0: txLoad = 8'b0000_0001;
            3'd1: txLoad = 8'b0000_0010;
            3'd2: txLoad = 8'b0000_0100;
            3'd3: txLoad = 8'b0000_1000;
            3'd4: txLoad = 8'b0001_0000;
            3'd5: txLoad = 8'b0010_0000;
            3'd6: txLoad = 8'b0100_0000;
            3'd7: txLoad = 8'b1000_0000;
            default: txLoad = '0;
         endcase
      end
   end

   ////////////////////////////////////////
   // Data path
   ////////////////////////////////////////

   // Same byte to all lines; only the loaded one takes it
   assign txData = tdrData;

endmodule

/* hdl/dzTx.sv */
/*
 * Top level of the eight-line transmit multiplexer.
 * APB slave register block, TDR decode, line scanner and one 8N1
 * transmitter per line. No wait states; PSLVERR is never raised.
 */

`timescale 1ns/100ps

module dzTx import dzPkg::*; (
      input  logic       clk,        // Clock
      input  logic       rstN,       // Async reset, active low
      input  logic       psel,       // APB select
      input  logic       penable,    // APB access phase
      input  logic       pwrite,     // APB write
      input  apbAddrT    paddr,      // APB byte address
      input  regDataT    pwdata,     // APB write data
      input  logic [1:0] pstrb,      // APB byte strobes
      output regDataT    prdata,     // APB read data
      output logic       pready,     // Always ready
      output logic       pslverr,    // Never an error
      output lineMaskT   txd         // Serial outputs
   );

   logic     tdrWrite;
   uartDataT tdrData;
   logic     mse;
   lineMaskT lineEnable;
   logic     trdy;
   lineSelT  tLine;
   lineMaskT txLoad;
   uartDataT txData;
   lineMaskT txEmpty;

   // Zero wait states, no slave errors
   assign pready  = 1'b1;
   assign pslverr = 1'b0;

   ////////////////////////////////////////
   // Register block
   ////////////////////////////////////////

   dzCsr u_dzCsr (
      .clk        (clk),
      .rstN       (rstN),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .pstrb      (pstrb),
      .trdy       (trdy),
      .tLine      (tLine),
      .prdata     (prdata),
      .tdrWrite   (tdrWrite),
      .tdrData    (tdrData),
      .mse        (mse),
      .lineEnable (lineEnable)
   );

   // TDR write to one-hot load
   dzTdr u_dzTdr (
      .tdrWrite (tdrWrite),
      .tLine    (tLine),
      .tdrData  (tdrData),
      .txLoad   (txLoad),
      .txData   (txData)
   );

   // Finds the next enabled empty line
   dzScan u_dzScan (
      .clk        (clk),
      .rstN       (rstN),
      .mse        (mse),
      .lineEnable (lineEnable),
      .txEmpty    (txEmpty),
      .trdy       (trdy),
      .tLine      (tLine)
   );

   ////////////////////////////////////////
   // Per-line transmitters
   ////////////////////////////////////////

   for (genvar line = 0; line < numLines; line++)
   begin : gLine
      dzUartTx u_dzUartTx (
         .clk     (clk),
         .rstN    (rstN),
         .load    (txLoad[line]),
         .data    (txData),
         .txd     (txd[line]),
         .txEmpty (txEmpty[line])
      );
   end

endmodule

/* hdl/dzUartTx.sv */
/*
 * Single-line 8N1 serial transmitter.
 * A load while idle starts a frame on the next edge: start bit,
 * eight data bits LSB first, one stop bit. Loads while busy are
 * dropped. txEmpty is high only when idle.
 */

`timescale 1ns/100ps

module dzUartTx import dzPkg::*; (
      input  logic     clk,       // Clock
      input  logic     rstN,      // Async reset, active low
      input  logic     load,      // Load strobe from TDR decode
      input  uartDataT data,      // Byte to send
      output logic     txd,       // Serial output, idles high
      output logic     txEmpty    // Transmitter idle
   );

   txStateT              state;
   logic [bitCntW-1:0]   bitCnt;
   logic [2:0]           bitIdx;
   uartDataT             shiftReg;
   logic                 bitEnd;
   logic                 start;

   // Last clock of the current bit
   assign bitEnd = (bitCnt == bitCntW'(clksPerBit - 1));

   // Loads while busy are ignored
   assign start  = (state == txIdle) & load;

   ////////////////////////////////////////
   // Frame FSM
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         state  <= txIdle;
         bitCnt <= '0;
         bitIdx <= '0;
      end
      else
      begin
         // Bit timer runs outside idle
         if (state == txIdle || bitEnd)
            bitCnt <= '0;
         else
            bitCnt <= bitCnt + 1'b1;

         case (state)
            txIdle:
               if (start)
                  state <= txStart;
            txStart:
               if (bitEnd)
               begin
                  state  <= txData;
                  bitIdx <= '0;
               end
            txData:
               if (bitEnd)
               begin
                  // Eighth bit done
                  if (bitIdx == 3'd7)
                     state <= txStop;
                  bitIdx <= bitIdx + 1'b1;
               end
            txStop:
               if (bitEnd)
                  state <= txIdle;
            default:
               state <= txIdle;
         endcase
      end
   end

   // Shifter, LSB goes out first
   always_ff @(posedge clk)
   begin
      if (start)
         shiftReg <= data;
      else if (state == txData && bitEnd)
         shiftReg <= {1'b1, shiftReg[7:1]};
   end

   ////////////////////////////////////////
   // Outputs
   ////////////////////////////////////////

   always_comb
   begin
      case (state)
         txStart: txd = 1'b0;
         txData:  txd = shiftReg[0];
         default: txd = 1'b1;
      endcase
   end

   assign txEmpty = (state == txIdle);

endmodule

/* run.sh */
#!/bin/sh
# Build and run the dzTx regression with Verilator.
# Exit status is non-zero when the run reports failure.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --top-module dzTxTb -f all.f > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Build failed"
   exit 1
fi

./obj_dir/VdzTxTb +verilator+error+limit+1000 > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "Regression failed" sim.log; then
   exit 1
fi
if [ $simStatus -ne 0 ]; then
   echo "Simulation exited with status $simStatus"
   exit 1
fi
if ! grep -q "Regression passed" sim.log; then
   echo "Simulation ended without a result"
   exit 1
fi
exit 0

/* tb/dzTxTb.sv */
/*
 * Testbench for the transmit multiplexer.
 * Drives APB on the falling edge, sends LFSR bytes through the scanner
 * and decodes every txd frame against the byte last written per line.
 */

`timescale 1ns/100ps

module dzTxTb import dzPkg::*; ;

   localparam int frameCycles   = 10 * clksPerBit;
   localparam int timeoutCycles = 20 * frameCycles * numLines + 200;

   logic clk = 1'b0;
   logic rstN = 1'b0;
   logic psel = 1'b0;
   logic penable = 1'b0;
   logic pwrite = 1'b0;
   apbAddrT paddr = '0;
   regDataT pwdata = '0;
   logic [1:0] pstrb = '0;
   regDataT prdata;
   logic pready;
   logic pslverr;
   lineMaskT txd;

   int errorCount = 0;
   int cycles = 0;
   logic [15:0] lfsr = 16'd12;
   lineMaskT expPend = '0;
   uartDataT expByte [numLines];

   dzTx u_dzTx (.*);

   always #50 clk = ~clk;

   // Watchdog
   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= timeoutCycles)
      begin
         errorCount++;
         $display("Timeout after %0d cycles, test did not finish", cycles);
         $display("Errors %0d, assertion failures %0d", errorCount,
                  u_dzTx.u_dzTxProperties.failCount);
         $display("Regression failed");
         $finish;
      end
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   function automatic logic [15:0] lfsrNext(input logic [15:0] s);
      logic fb;
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[14:0], fb};
   endfunction

   // One LFSR step per bit taken
   task automatic nextByte(output uartDataT b);
      for (int k = 0; k < 8; k++)
      begin
         lfsr = lfsrNext(lfsr);
         b[k] = lfsr[0];
      end
   endtask

   task automatic checkEqual(input string name, input regDataT got, input regDataT expv);
      assert (got == expv)
      else
      begin
         errorCount++;
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, expv);
      end
   endtask

   task automatic writeReg(input apbAddrT a, input regDataT d, input logic [1:0] s);
      @(negedge clk);
      psel = 1'b1;
      penable = 1'b0;
      pwrite = 1'b1;
      paddr = a;
      pwdata = d;
      pstrb = s;
      @(negedge clk);
      penable = 1'b1;
      @(negedge clk);
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
   endtask

   // Sampled mid access cycle, away from both edges
   task automatic readReg(input apbAddrT a, output regDataT d);
      @(negedge clk);
      psel = 1'b1;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = a;
      @(negedge clk);
      penable = 1'b1;
      #25 d = prdata;
      @(negedge clk);
      psel = 1'b0;
      penable = 1'b0;
   endtask

   task automatic waitReady(output lineSelT line);
      regDataT d;
      d = '0;
      while (!d[15])
         readReg(csrAddr, d);
      line = d[10:8];
   endtask

   // Byte to whatever line the scanner offers
   task automatic sendByte(input uartDataT b, output lineSelT line);
      waitReady(line);
      writeReg(tdrAddr, {8'h00, b}, 2'b01);
      expByte[line] = b;
      expPend[line] = 1'b1;
      // Let TRDY drop for the taken line
      repeat (3) @(negedge clk);
   endtask

   task automatic waitDrain();
      int n;
      n = 0;
      while (expPend != '0 && n < 2 * frameCycles * numLines)
      begin
         @(negedge clk);
         n++;
      end
      for (int i = 0; i < numLines; i++)
         if (expPend[i])
         begin
            errorCount++;
            $display("Expected frame on txd[%0d] never arrived", i);
            expPend[i] = 1'b0;
         end
   endtask

   ////////////////////////////////////////
   // Frame monitor
   ////////////////////////////////////////

   task automatic receiveFrame(input int line);
      uartDataT rx;
      logic stopBit;
      // Middle of the start bit
      repeat (clksPerBit / 2) @(negedge clk);
      assert (txd[line] == 1'b0)
      else
      begin
         errorCount++;
         $display("Start bit on txd[%0d] too short", line);
      end
      for (int k = 0; k < 8; k++)
      begin
         repeat (clksPerBit) @(negedge clk);
         rx[k] = txd[line];
      end
      repeat (clksPerBit) @(negedge clk);
      stopBit = txd[line];
      assert (stopBit == 1'b1)
      else
      begin
         errorCount++;
         $display("Missing stop bit on txd[%0d]", line);
      end
      assert (expPend[line])
      else
      begin
         errorCount++;
         $display("Unexpected frame on txd[%0d]", line);
      end
      if (expPend[line])
         checkEqual($sformatf("txd[%0d]", line), {8'h00, rx}, {8'h00, expByte[line]});
      expPend[line] = 1'b0;
   endtask

   for (genvar i = 0; i < numLines; i++)
   begin : gMon
      always @(negedge txd[i])
         if (rstN)
            receiveFrame(i);
   end

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial
   begin
      regDataT d;
      uartDataT b;
      uartDataT first;
      lineSelT line;
      repeat (2) @(negedge clk);
      rstN = 1'b1;

      // Reset values, TDR reads zero, high lane of TCR is not writable
      readReg(csrAddr, d);
      checkEqual("CSR", d, 16'h0000);
      readReg(tcrAddr, d);
      checkEqual("TCR", d, 16'h0000);
      readReg(tdrAddr, d);
      checkEqual("TDR", d, 16'h0000);
      writeReg(tcrAddr, 16'hffff, 2'b10);
      readReg(tcrAddr, d);
      checkEqual("TCR", d, 16'h0000);

      // Enabled and empty but MSE clear
      writeReg(tcrAddr, 16'h00ff, 2'b01);
      readReg(tcrAddr, d);
      checkEqual("TCR", d, 16'h00ff);
      repeat (10) @(negedge clk);
      readReg(csrAddr, d);
      checkEqual("TRDY", {15'b0, d[15]}, 16'h0000);

      // High-lane TDR write sends nothing
      writeReg(csrAddr, 16'h0020, 2'b01);
      readReg(csrAddr, d);
      checkEqual("MSE", {15'b0, d[5]}, 16'h0001);
      waitReady(line);
      writeReg(tdrAddr, 16'h5a5a, 2'b10);
      repeat (frameCycles + 10) @(negedge clk);

      // Random bytes through all lines
      for (int n = 0; n < 16; n++)
      begin
         nextByte(b);
         sendByte(b, line);
      end
      waitDrain();

      // Only lines 2 and 5 may be offered
      writeReg(tcrAddr, 16'h0024, 2'b01);
      repeat (10) @(negedge clk);
      for (int n = 0; n < 6; n++)
      begin
         nextByte(b);
         sendByte(b, line);
         assert (line == 3'd2 || line == 3'd5)
         else
         begin
            errorCount++;
            $display("mismatch at %0t: tLine got %0d expected 2 or 5", $time, line);
         end
      end
      waitDrain();

      // Second write to a busy line is dropped; pointer frozen with MSE clear
      writeReg(tcrAddr, 16'h00ff, 2'b01);
      waitReady(line);
      writeReg(csrAddr, 16'h0000, 2'b01);
      readReg(csrAddr, d);
      checkEqual("TRDY", {15'b0, d[15]}, 16'h0000);
      line = d[10:8];
      nextByte(first);
      nextByte(b);
      writeReg(tdrAddr, {8'h00, first}, 2'b01);
      expByte[line] = first;
      expPend[line] = 1'b1;
      writeReg(tdrAddr, {8'h00, b}, 2'b01);
      waitDrain();
      // Room for a stray second frame to show up
      repeat (2 * frameCycles) @(negedge clk);

      $display("Errors %0d, assertion failures %0d", errorCount,
               u_dzTx.u_dzTxProperties.failCount);
      if (errorCount == 0 && u_dzTx.u_dzTxProperties.failCount == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

/* tb/dzTx_properties.sv */
/*
 * Concurrent checks on the transmit multiplexer top level.
 * Bound into every dzTx instance; failCount holds the number of
 * failed checks so far.
 */

`timescale 1ns/100ps

module dzTxProperties import dzPkg::*; (
      input logic     clk,
      input logic     rstN,
      input logic     pready,
      input logic     pslverr,
      input lineMaskT txLoad,
      input logic     trdy,
      input logic     mse,
      input lineMaskT lineEnable,
      input lineSelT  tLine,
      input lineMaskT txEmpty,
      input lineMaskT txd
   );

   int failCount = 0;

   ////////////////////////////////////////
   // APB response
   ////////////////////////////////////////

   apbResp: assert property (@(posedge clk) disable iff (!rstN)
      pready && !pslverr)
      else begin failCount++; $error("APB pready or pslverr wrong"); end

   ////////////////////////////////////////
   // Load, scanner and line checks
   ////////////////////////////////////////

   // At most one line loaded per cycle
   loadOneHot: assert property (@(posedge clk) disable iff (!rstN)
      $onehot0(txLoad))
      else begin failCount++; $error("txLoad not one-hot"); end

   // TRDY only follows a qualified line
   trdyQual: assert property (@(posedge clk) disable iff (!rstN)
      trdy |-> $past(mse && lineEnable[tLine] && txEmpty[tLine]))
      else begin failCount++; $error("trdy without a ready line"); end

   // Idle lines sit at mark
   idleMark: assert property (@(posedge clk) disable iff (!rstN)
      (txEmpty & ~txd) == '0)
      else begin failCount++; $error("idle line not high"); end

   // Pointer held while ready
   lineHold: assert property (@(posedge clk) disable iff (!rstN)
      trdy && $past(trdy) && ($past(txLoad) == '0) |-> $stable(tLine))
      else begin failCount++; $error("tLine moved while trdy"); end

endmodule

bind dzTx dzTxProperties u_dzTxProperties (
   .clk        (clk),
   .rstN       (rstN),
   .pready     (pready),
   .pslverr    (pslverr),
   .txLoad     (txLoad),
   .trdy       (trdy),
   .mse        (mse),
   .lineEnable (lineEnable),
   .tLine      (tLine),
   .txEmpty    (txEmpty),
   .txd        (txd)
);
